// ==== verilog/ifu_cfg_pkg.sv ====
package ifu_cfg_pkg;

  // byte address in instruction space
  typedef logic [31:0] addr_t;

  // default set index width
  localparam int IDX_BITS = 2;

  // two words per line
  localparam int OFS_BITS = 1;

  // byte offset inside a 32-bit word
  localparam int BYTE_BITS = 2;

  // word select inside a line
  typedef logic [OFS_BITS-1:0] ofs_t;

  // line refill sequence
  typedef enum logic [2:0] {
    FILL_IDLE,
    FILL_REQ0,
    FILL_GAP,
    FILL_REQ1,
    FILL_DONE
  } fill_state_t;

  localparam addr_t PC_INIT = 32'h8000_0000;

endpackage

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef logic [31:0] inst_t;

  // major opcode field in inst[6:0]
  typedef logic [6:0] opcode_t;

  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;

  // fence.i with rd, rs1 and imm all zero
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

endpackage

// ==== verilog/l1i_cache.sv ====
`timescale 1ns/1ps

module l1i_cache #(
  parameter int IDX_BITS = ifu_cfg_pkg::IDX_BITS
) (
  input  logic               clk,
  input  logic               rst,
  input  ifu_cfg_pkg::addr_t fetch_pc_i,
  input  logic               invalidate_i,
  output logic               hit_o,
  output logic               idle_o,
  output rv_isa_pkg::inst_t  inst_o,
  output ifu_cfg_pkg::addr_t ifu_araddr_o,
  output logic               ifu_arvalid_o,
  input  rv_isa_pkg::inst_t  ifu_rdata_i,
  input  logic               ifu_rvalid_i
);
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;

  localparam int SETS      = 2 ** IDX_BITS;
  localparam int WORDS     = 2 ** OFS_BITS;
  localparam int ADDR_BITS = $bits(addr_t);
  localparam int LINE_LSB  = OFS_BITS + BYTE_BITS;
  localparam int LINE_BITS = ADDR_BITS - LINE_LSB;
  localparam int TAG_BITS  = LINE_BITS - IDX_BITS;

  inst_t                data_q [SETS][WORDS];
  logic [TAG_BITS-1:0]  tag_q [SETS];
  logic [SETS-1:0]      line_valid_q;
  fill_state_t          state_q;
  logic [LINE_BITS-1:0] fill_line_q;

  logic [TAG_BITS-1:0]  pc_tag;
  logic [IDX_BITS-1:0]  pc_idx;
  ofs_t                 pc_ofs;
  logic [IDX_BITS-1:0]  fill_idx;
  ofs_t                 req_ofs;
  logic                 lookup_hit;
  logic                 fwd_word1;

  // fetch address split
  assign pc_tag = fetch_pc_i[ADDR_BITS-1:LINE_LSB+IDX_BITS];
  assign pc_idx = fetch_pc_i[LINE_LSB+IDX_BITS-1:LINE_LSB];
  assign pc_ofs = fetch_pc_i[LINE_LSB-1:BYTE_BITS];

  assign fill_idx = fill_line_q[IDX_BITS-1:0];
  assign req_ofs  = (state_q == FILL_REQ1) ? ofs_t'(1) : ofs_t'(0);

  // array is only consulted when no refill is half written
  assign lookup_hit = ((state_q == FILL_IDLE) || (state_q == FILL_DONE)) &&
                      line_valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  // word 1 goes out the cycle it lands
  assign fwd_word1 = (state_q == FILL_REQ1) && ifu_rvalid_i &&
                     (fetch_pc_i[ADDR_BITS-1:LINE_LSB] == fill_line_q) &&
                     (pc_ofs == ofs_t'(1));

  assign hit_o  = lookup_hit || fwd_word1;
  assign inst_o = fwd_word1 ? ifu_rdata_i : data_q[pc_idx][pc_ofs];
  assign idle_o = (state_q == FILL_IDLE);

  assign ifu_arvalid_o = (state_q == FILL_REQ0) || (state_q == FILL_REQ1);
  assign ifu_araddr_o  = {fill_line_q, req_ofs, {BYTE_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= FILL_IDLE;
      line_valid_q <= '0;
    end else begin
      case (state_q)
        FILL_IDLE: begin
          if (!lookup_hit) begin
            state_q <= FILL_REQ0;
          end
        end
        FILL_REQ0: begin
          if (ifu_rvalid_i) begin
            state_q <= FILL_GAP;
          end
        end
        FILL_GAP: begin
          state_q <= FILL_REQ1;
        end
        FILL_REQ1: begin
          if (ifu_rvalid_i) begin
            state_q                <= FILL_DONE;
            line_valid_q[fill_idx] <= 1'b1;
          end
        end
        FILL_DONE: begin
          state_q <= FILL_IDLE;
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
      // fence.i wins over a line landing in the same cycle
      if (invalidate_i) begin
        line_valid_q <= '0;
      end
    end
  end

  // line address is held for the whole refill
  always_ff @(posedge clk) begin
    if (state_q == FILL_IDLE) begin
      fill_line_q <= fetch_pc_i[ADDR_BITS-1:LINE_LSB];
    end
    if ((state_q == FILL_REQ0) && ifu_rvalid_i) begin
      data_q[fill_idx][0] <= ifu_rdata_i;
      tag_q[fill_idx]     <= fill_line_q[LINE_BITS-1:IDX_BITS];
    end
    if ((state_q == FILL_REQ1) && ifu_rvalid_i) begin
      data_q[fill_idx][1] <= ifu_rdata_i;
    end
  end

endmodule

// ==== verilog/branch_speculator.sv ====
`timescale 1ns/1ps

module branch_speculator (
  input  logic               clk,
  input  logic               rst,
  input  ifu_cfg_pkg::addr_t fetch_pc_i,
  input  logic               train_i,
  input  logic               train_cond_i,
  input  logic               flush_done_i,
  input  ifu_cfg_pkg::addr_t resolve_npc_i,
  input  logic               pc_change_i,
  input  logic               pc_retire_i,
  input  ifu_cfg_pkg::addr_t pc_i,
  output logic               pred_valid_o,
  output ifu_cfg_pkg::addr_t pred_target_o,
  output logic               spec_o,
  output logic               good_spec_o,
  output logic               bad_spec_o,
  output ifu_cfg_pkg::addr_t recover_pc_o
);
  import ifu_cfg_pkg::*;

  addr_t btb_target_q;
  logic  btb_valid_q;
  logic  spec_q;
  addr_t spec_target_q;
  addr_t fall_through_q;
  logic  spec_cond_q;
  logic  good_q;
  logic  bad_q;
  addr_t recover_q;

  logic  resolving;
  logic  match;
  logic  bad_now;
  addr_t recover_now;

  assign resolving = pc_change_i || pc_retire_i;
  assign match     = (pc_change_i && (resolve_npc_i == spec_target_q)) ||
                     (pc_retire_i && ((pc_i + addr_t'(4)) == spec_target_q));
  assign bad_now   = spec_q && resolving && !match;

  // not-taken conditional resumes at its fall-through
  assign recover_now = (spec_cond_q && pc_retire_i) ? fall_through_q : resolve_npc_i;

  assign pred_valid_o  = btb_valid_q;
  assign pred_target_o = btb_target_q;
  assign spec_o        = spec_q;
  assign good_spec_o   = good_q;
  assign bad_spec_o    = bad_q || bad_now;
  assign recover_pc_o  = bad_q ? recover_q : recover_now;

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= spec_q && resolving && match;
      bad_q  <= !flush_done_i && (bad_q || bad_now);
      if (pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      if (spec_q && resolving) begin
        spec_q <= 1'b0;
      end else if (train_i && btb_valid_q) begin
        spec_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_change_i) begin
      btb_target_q <= resolve_npc_i;
    end
    if (train_i && btb_valid_q && !spec_q) begin
      spec_target_q  <= btb_target_q;
      fall_through_q <= fetch_pc_i + addr_t'(4);
      spec_cond_q    <= train_cond_i;
    end
    if (bad_now) begin
      recover_q <= recover_now;
    end
  end

endmodule

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               hit_i,
  input  logic               idle_i,
  input  rv_isa_pkg::inst_t  inst_i,
  input  logic               pred_valid_i,
  input  ifu_cfg_pkg::addr_t pred_target_i,
  input  logic               spec_i,
  input  logic               bad_spec_i,
  input  ifu_cfg_pkg::addr_t recover_pc_i,
  input  ifu_cfg_pkg::addr_t npc_i,
  input  logic               pc_change_i,
  input  logic               pc_retire_i,
  input  logic               next_ready_i,
  output ifu_cfg_pkg::addr_t fetch_pc_o,
  output logic               train_o,
  output logic               train_cond_o,
  output logic               flush_done_o,
  output logic               invalidate_o,
  output logic               valid_o,
  output logic               ready_o,
  output ifu_cfg_pkg::addr_t pc_o,
  output rv_isa_pkg::inst_t  inst_o
);
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;

  addr_t   pc_q;
  logic    hazard_q;

  opcode_t opcode;
  logic    is_branch;
  logic    is_cond;
  logic    is_load;
  logic    is_store;
  logic    is_fence;
  logic    accept;
  logic    recover;

  // decode just enough to know when to stop
  assign opcode    = inst_i[6:0];
  assign is_cond   = (opcode == OP_BRANCH);
  assign is_branch = (opcode == OP_JAL) || (opcode == OP_JALR) || is_cond ||
                     (opcode == OP_SYSTEM);
  assign is_load   = (opcode == OP_LOAD);
  assign is_store  = (opcode == OP_STORE);
  assign is_fence  = (inst_i == INST_FENCE_I);

  // memory ops never leave while a prediction is open
  assign valid_o = hit_i && !hazard_q && !bad_spec_i && !(spec_i && (is_load || is_store));
  assign ready_o = !valid_o;
  assign accept  = valid_o && next_ready_i;
  assign recover = bad_spec_i && idle_i && next_ready_i;

  assign train_o      = accept && is_branch && !spec_i;
  assign train_cond_o = is_cond;
  assign flush_done_o = recover;
  assign invalidate_o = accept && is_fence;

  assign fetch_pc_o = pc_q;
  assign pc_o       = pc_q;
  assign inst_o     = inst_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= PC_INIT;
      hazard_q <= 1'b0;
    end else if (bad_spec_i) begin
      if (recover) begin
        pc_q     <= recover_pc_i;
        hazard_q <= 1'b0;
      end
    end else if (hazard_q) begin
      // resolutions during a prediction belong to the speculator
      if (!spec_i && pc_change_i) begin
        pc_q     <= npc_i;
        hazard_q <= 1'b0;
      end else if (!spec_i && pc_retire_i) begin
        pc_q     <= pc_q + addr_t'(4);
        hazard_q <= 1'b0;
      end
    end else if (accept) begin
      if (is_branch && pred_valid_i && !spec_i) begin
        pc_q <= pred_target_i;
      end else if (is_branch || is_load || is_fence) begin
        hazard_q <= 1'b1;
      end else begin
        pc_q <= pc_q + addr_t'(4);
      end
    end
  end

endmodule

// ==== verilog/ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top #(
  parameter int IDX_BITS = ifu_cfg_pkg::IDX_BITS
) (
  input  logic               clk,
  input  logic               rst,
  output ifu_cfg_pkg::addr_t ifu_araddr_o,
  output logic               ifu_arvalid_o,
  input  rv_isa_pkg::inst_t  ifu_rdata_i,
  input  logic               ifu_rvalid_i,
  input  ifu_cfg_pkg::addr_t npc_i,
  input  ifu_cfg_pkg::addr_t pc_i,
  input  logic               pc_change_i,
  input  logic               pc_retire_i,
  input  logic               next_ready_i,
  output logic               valid_o,
  output logic               ready_o,
  output ifu_cfg_pkg::addr_t pc_o,
  output rv_isa_pkg::inst_t  inst_o,
  output logic               spec_o,
  output logic               good_spec_o,
  output logic               bad_spec_o
);
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;

  addr_t fetch_pc;
  logic  hit;
  logic  idle;
  inst_t cache_inst;
  logic  pred_valid;
  addr_t pred_target;
  addr_t recover_pc;
  logic  train;
  logic  train_cond;
  logic  flush_done;
  logic  invalidate;

  l1i_cache #(
    .IDX_BITS(IDX_BITS)
  ) u_l1i_cache (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .invalidate_i (invalidate),
    .hit_o        (hit),
    .idle_o       (idle),
    .inst_o       (cache_inst),
    .ifu_araddr_o (ifu_araddr_o),
    .ifu_arvalid_o(ifu_arvalid_o),
    .ifu_rdata_i  (ifu_rdata_i),
    .ifu_rvalid_i (ifu_rvalid_i)
  );

  // cache and predictor look at the same pc side by side
  branch_speculator u_branch_speculator (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .train_i      (train),
    .train_cond_i (train_cond),
    .flush_done_i (flush_done),
    .resolve_npc_i(npc_i),
    .pc_change_i  (pc_change_i),
    .pc_retire_i  (pc_retire_i),
    .pc_i         (pc_i),
    .pred_valid_o (pred_valid),
    .pred_target_o(pred_target),
    .spec_o       (spec_o),
    .good_spec_o  (good_spec_o),
    .bad_spec_o   (bad_spec_o),
    .recover_pc_o (recover_pc)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .hit_i        (hit),
    .idle_i       (idle),
    .inst_i       (cache_inst),
    .pred_valid_i (pred_valid),
    .pred_target_i(pred_target),
    .spec_i       (spec_o),
    .bad_spec_i   (bad_spec_o),
    .recover_pc_i (recover_pc),
    .npc_i        (npc_i),
    .pc_change_i  (pc_change_i),
    .pc_retire_i  (pc_retire_i),
    .next_ready_i (next_ready_i),
    .fetch_pc_o   (fetch_pc),
    .train_o      (train),
    .train_cond_o (train_cond),
    .flush_done_o (flush_done),
    .invalidate_o (invalidate),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .pc_o         (pc_o),
    .inst_o       (inst_o)
  );

endmodule

// ==== tb/bus_mem_model.sv ====
`timescale 1ns/1ps

module bus_mem_model #(
  parameter int          DEPTH = 8,
  parameter int          DELAY = 2,
  parameter logic [31:0] BASE  = 32'h0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);
  logic [31:0] mem [DEPTH];
  logic [31:0] word_idx;
  logic        busy;
  int          wait_cnt;

  assign word_idx = (araddr_i - BASE) >> 2;

  task automatic write_word(input int idx, input logic [31:0] data);
    mem[idx] = data;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      busy     <= 1'b0;
      wait_cnt <= 0;
    end else begin
      rvalid_o <= 1'b0;
      if (rvalid_o) begin
        // request ends on this edge
        busy <= 1'b0;
      end else if (!busy && arvalid_i) begin
        busy     <= 1'b1;
        wait_cnt <= DELAY - 1;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          rvalid_o <= 1'b1;
          // inverted address outside the program
          rdata_o  <= (word_idx < DEPTH) ? mem[word_idx] : ~araddr_i;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

// ==== tb/tb_ifu_top.sv ====
`timescale 1ns/1ps

module tb_ifu_top;
  import ifu_cfg_pkg::*;
  import rv_isa_pkg::*;

  localparam int N_TESTS    = 18;
  localparam int PROG_WORDS = 8;
  // cycles from acceptance to the back-end answer
  localparam int RES_DELAY  = 3;
  localparam int MAX_CYCLES = 200 * N_TESTS;

  typedef enum logic [1:0] {RES_NONE, RES_RETIRE, RES_CHANGE} res_t;
  typedef enum logic [1:0] {SPEC_NONE, SPEC_GOOD, SPEC_BAD} spec_t;
  // bus traffic since the previous delivery
  typedef enum logic {BUS_QUIET, BUS_MISS} bus_t;

  logic  clk = 1'b0;
  logic  rst;
  addr_t ifu_araddr;
  logic  ifu_arvalid;
  inst_t ifu_rdata;
  logic  ifu_rvalid;
  addr_t npc;
  addr_t pc_in;
  logic  pc_change;
  logic  pc_retire;
  logic  next_ready;
  logic  valid;
  logic  ready;
  addr_t pc_out;
  inst_t inst_out;
  logic  spec;
  logic  good_spec;
  logic  bad_spec;

  inst_t prog [PROG_WORDS];
  addr_t pc_ofs [N_TESTS];
  res_t  res_kind [N_TESTS];
  addr_t res_tgt [N_TESTS];
  spec_t spec_exp [N_TESTS];
  bus_t  bus_exp [N_TESTS];
  string test_name [N_TESTS];
  int    test_err [N_TESTS];

  int          i;
  int          n_loaded;
  int          cur;
  int          pend;
  int          owner;
  int          res_wait;
  int          cycles;
  int          errors;
  int          n_pass;
  int          n_fail;
  logic        firing;
  logic        report_due;
  logic        bus_seen;
  logic [31:0] seed;

  ifu_top #(
    .IDX_BITS(IDX_BITS)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .ifu_araddr_o (ifu_araddr),
    .ifu_arvalid_o(ifu_arvalid),
    .ifu_rdata_i  (ifu_rdata),
    .ifu_rvalid_i (ifu_rvalid),
    .npc_i        (npc),
    .pc_i         (pc_in),
    .pc_change_i  (pc_change),
    .pc_retire_i  (pc_retire),
    .next_ready_i (next_ready),
    .valid_o      (valid),
    .ready_o      (ready),
    .pc_o         (pc_out),
    .inst_o       (inst_out),
    .spec_o       (spec),
    .good_spec_o  (good_spec),
    .bad_spec_o   (bad_spec)
  );

  bus_mem_model #(
    .DEPTH(PROG_WORDS),
    .DELAY(2),
    .BASE (PC_INIT)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .araddr_i (ifu_araddr),
    .arvalid_i(ifu_arvalid),
    .rdata_o  (ifu_rdata),
    .rvalid_o (ifu_rvalid)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_equal(input int t, input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    string nm;
    nm = (t < 0) ? "reset" : test_name[t];
    if (exp_v !== act_v) begin
      $display("ERROR %s %s expected %h actual %h", nm, what, exp_v, act_v);
      errors++;
      if (t >= 0) begin
        test_err[t]++;
      end
    end
  endtask

  task automatic report_test(input int t);
    if (test_err[t] == 0) begin
      $display("test %s passed", test_name[t]);
      n_pass++;
    end else begin
      $display("test %s failed with %0d mismatches", test_name[t], test_err[t]);
      n_fail++;
    end
  endtask

  task automatic add_test(input addr_t ofs, input res_t r, input addr_t tgt, input spec_t s,
                          input bus_t b, input string n);
    pc_ofs[n_loaded]    = ofs;
    res_kind[n_loaded]  = r;
    res_tgt[n_loaded]   = tgt;
    spec_exp[n_loaded]  = s;
    bus_exp[n_loaded]   = b;
    test_name[n_loaded] = n;
    n_loaded++;
  endtask

  initial begin
    rst        = 1'b1;
    npc        = '0;
    pc_in      = '0;
    pc_change  = 1'b0;
    pc_retire  = 1'b0;
    next_ready = 1'b0;
    seed       = 32'h987d16e8;
    n_loaded   = 0;
    cur        = 0;
    pend       = 0;
    res_wait   = 0;
    cycles     = 0;
    errors     = 0;
    n_pass     = 0;
    n_fail     = 0;
    firing     = 1'b0;
    report_due = 1'b0;
    bus_seen   = 1'b0;

    prog[0] = 32'h0010_0093;  // addi x1, x0, 1
    prog[1] = 32'h0020_0113;  // addi x2, x0, 2
    prog[2] = 32'h0000_2183;  // lw x3, 0(x0)
    prog[3] = 32'h0010_8093;  // addi x1, x1, 1
    prog[4] = 32'hfff1_0113;  // addi x2, x2, -1
    prog[5] = 32'hfe20_8ae3;  // beq x1, x2, -12
    prog[6] = 32'h0000_100f;  // fence.i
    prog[7] = 32'hfe5f_f06f;  // jal x0, -28
    for (i = 0; i < PROG_WORDS; i++) begin
      u_mem.write_word(i, prog[i]);
    end

    // pc offset, back-end answer, target offset, grading, bus, name
    add_test(32'h00, RES_NONE,   32'h00, SPEC_NONE, BUS_MISS,  "straight_0");
    add_test(32'h04, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "straight_1");
    add_test(32'h08, RES_RETIRE, 32'h00, SPEC_NONE, BUS_MISS,  "load_first");
    add_test(32'h0c, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "after_load");
    add_test(32'h10, RES_NONE,   32'h00, SPEC_NONE, BUS_MISS,  "straight_2");
    add_test(32'h14, RES_CHANGE, 32'h08, SPEC_NONE, BUS_QUIET, "branch_first");
    add_test(32'h08, RES_RETIRE, 32'h00, SPEC_NONE, BUS_QUIET, "loop2_load");
    add_test(32'h0c, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "loop2_a");
    add_test(32'h10, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "loop2_b");
    add_test(32'h14, RES_CHANGE, 32'h08, SPEC_GOOD, BUS_QUIET, "pred_good");
    add_test(32'h08, RES_RETIRE, 32'h00, SPEC_NONE, BUS_QUIET, "loop3_load");
    add_test(32'h0c, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "loop3_a");
    add_test(32'h10, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "loop3_b");
    add_test(32'h14, RES_RETIRE, 32'h00, SPEC_BAD,  BUS_QUIET, "pred_bad_retire");
    add_test(32'h18, RES_RETIRE, 32'h00, SPEC_NONE, BUS_MISS,  "fence_i");
    add_test(32'h1c, RES_CHANGE, 32'h00, SPEC_BAD,  BUS_MISS,  "pred_bad_change");
    add_test(32'h00, RES_NONE,   32'h00, SPEC_NONE, BUS_MISS,  "refetch_after_fence");
    add_test(32'h04, RES_NONE,   32'h00, SPEC_NONE, BUS_QUIET, "straight_3");

    repeat (5) @(posedge clk);
    #1;
    check_equal(-1, "ifu_arvalid_o", 0, ifu_arvalid);
    check_equal(-1, "valid_o", 0, valid);
    check_equal(-1, "ready_o", 1, ready);
    check_equal(-1, "spec_o", 0, spec);
    check_equal(-1, "good_spec_o", 0, good_spec);
    check_equal(-1, "bad_spec_o", 0, bad_spec);
    rst = 1'b0;

    while ((n_pass + n_fail) < N_TESTS && cycles < MAX_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      pc_change = 1'b0;
      pc_retire = 1'b0;
      if (res_wait > 0) begin
        res_wait--;
        if (res_wait == 0) begin
          firing = 1'b1;
          pc_in  = PC_INIT + pc_ofs[pend];
          npc    = PC_INIT + res_tgt[pend];
          if (res_kind[pend] == RES_CHANGE) begin
            pc_change = 1'b1;
          end else begin
            pc_retire = 1'b1;
          end
        end
      end
      seed = lcg_next(seed);
      // about one stall cycle in four
      next_ready = (seed[31:30] != 2'b00);
      #3;
      bus_seen = bus_seen | ifu_arvalid;
      owner = (cur < N_TESTS) ? cur : N_TESTS - 1;
      if (report_due) begin
        owner = pend;
      end
      check_equal(owner, "good_spec_o", report_due && (spec_exp[pend] == SPEC_GOOD), good_spec);
      if (report_due) begin
        report_test(pend);
        report_due = 1'b0;
      end
      if (firing) begin
        check_equal(pend, "bad_spec_o", spec_exp[pend] == SPEC_BAD, bad_spec);
        check_equal(pend, "spec_o", spec_exp[pend] != SPEC_NONE, spec);
        check_equal(pend, "valid_o", 0, valid);
        firing     = 1'b0;
        report_due = 1'b1;
      end else if (res_wait > 0) begin
        // nothing leaves while the back end has not answered
        check_equal(pend, "valid_o", 0, valid);
        check_equal(pend, "ready_o", 1, ready);
      end
      if (valid && next_ready && cur < N_TESTS) begin
        check_equal(cur, "pc_o", PC_INIT + pc_ofs[cur], pc_out);
        check_equal(cur, "inst_o", prog[pc_ofs[cur] >> 2], inst_out);
        check_equal(cur, "ready_o", 0, ready);
        check_equal(cur, "bus fill", bus_exp[cur] == BUS_MISS, bus_seen);
        bus_seen = 1'b0;
        if (res_kind[cur] == RES_NONE) begin
          report_test(cur);
        end else begin
          pend     = cur;
          res_wait = RES_DELAY;
        end
        cur++;
      end
    end

    if ((n_pass + n_fail) < N_TESTS) begin
      $display("timeout: only %0d of %0d tests finished within %0d cycles",
               n_pass + n_fail, N_TESTS, MAX_CYCLES);
      errors++;
    end
    $display("%0d tests: %0d passed, %0d failed, %0d mismatches",
             N_TESTS, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== ifu_top.f ====
verilog/ifu_cfg_pkg.sv
verilog/rv_isa_pkg.sv
verilog/l1i_cache.sv
verilog/branch_speculator.sv
verilog/fetch_ctrl.sv
verilog/ifu_top.sv
tb/bus_mem_model.sv
tb/tb_ifu_top.sv
